// ==== sources.f ====
+incdir+logic
logic/pd_pkg.sv
logic/instr_reg.sv
logic/group_decoder.sv
logic/sub_op_decoder.sv
logic/cond_eval.sv
logic/pd_unit.sv
tests/pd_checker.sv
tests/tb_pd_unit.sv

// ==== Bender.yml ====
package:
  name: pd_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/pd_pkg.sv
      - logic/instr_reg.sv
      - logic/group_decoder.sv
      - logic/sub_op_decoder.sv
      - logic/cond_eval.sv
      - logic/pd_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/pd_checker.sv
      - tests/tb_pd_unit.sv

// ==== tests/tb_pd_unit.sv ====
/* Directed and LCG stimulus for pd_unit, driven on the falling clock edge.
   One word is loaded per cycle; the run stops at a limit set by stimulus length. */

`include "pd_defs.svh"

module tb_pd_unit
	import pd_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 8;
	localparam int N_RAND       = 2000;
	localparam int N_SHORT      = 200;
	localparam int N_JUMP       = 400;
	localparam int N_FORCE      = 200;  // p, q with S, q with I/O, md
	localparam int N_ILLEGAL    = 200;
	localparam int N_MISC       = 16;   // Idle, strobe and drain cycles
	localparam int STIM_CYCLES  = RESET_CYCLES + N_RAND + N_SHORT + N_JUMP + N_FORCE
		+ N_ILLEGAL + N_MISC;
	localparam int MAX_CYCLES   = 2 * STIM_CYCLES + 100;

	logic                clk;
	logic                rst_n;
	logic [`PD_IR_W-1:0] w;
	logic                strob1;
	logic                w_ir;
	logic                si1;
	logic                q;
	logic                p;
	logic                mc_3;
	cond_flags_s         r0;
	ir_word_u            ir;
	pd_ctrl_s            ctrl;
	int                  check_count;
	int                  error_count;
	int                  cycles = 0;
	logic [31:0]         rnd_state = 32'h673d575e;

	pd_unit pd_unit_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.w      (w),
		.strob1 (strob1),
		.w_ir   (w_ir),
		.si1    (si1),
		.q      (q),
		.p      (p),
		.mc_3   (mc_3),
		.r0     (r0),
		.ir     (ir),
		.ctrl   (ctrl)
	);

	pd_checker checker_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.w           (w),
		.strob1      (strob1),
		.w_ir        (w_ir),
		.si1         (si1),
		.q           (q),
		.p           (p),
		.mc_3        (mc_3),
		.r0          (r0),
		.ir          (ir),
		.ctrl        (ctrl),
		.check_count (check_count),
		.error_count (error_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_random(output logic [15:0] v);
		rnd_state = lcg_next(rnd_state);
		v = rnd_state[31:16];  // Upper bits have the longest period
	endtask

	function automatic logic [15:0] instr_word(input logic [1:0] grp, input logic [3:0] op,
		input logic d, input logic [2:0] a, input logic [5:0] lo);
		return {grp, op, d, a, lo};
	endfunction

	task automatic drive(input logic [15:0] word, input logic ld_s, input logic ld_w,
		input logic sup, input logic qi, input logic pi, input logic mci,
		input cond_flags_s flags);
		@(negedge clk);
		w = word;
		strob1 = ld_s;
		w_ir = ld_w;
		si1 = sup;
		q = qi;
		p = pi;
		mc_3 = mci;
		r0 = flags;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		logic [15:0] r;
		logic [15:0] f;
		logic [2:0]  a_bad;
		logic [2:0]  b_bad;
		rst_n = 1'b0;
		w = '0;
		strob1 = 1'b0;
		w_ir = 1'b0;
		si1 = 1'b0;
		q = 1'b0;
		p = 1'b0;
		mc_3 = 1'b0;
		r0 = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		drive(16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);  // Reset state
		drive(16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		drive(16'h5a3c, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0);  // Load
		drive(16'hffff, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);  // strob1 alone holds
		drive(16'h1234, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0);  // w_ir alone holds
		drive(16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		for (int i = 0; i < N_RAND; i++) begin
			draw_random(r);
			draw_random(f);
			drive(r, 1'b1, 1'b1, f[1:0] == 2'd0, f[4:2] == 3'd0, f[7:5] == 3'd0, f[8],
				{f[15:9], f[1:0]});
		end
		for (int i = 0; i < N_SHORT; i++) begin
			draw_random(r);
			drive(instr_word(2'b01, {2'b10, r[1:0]}, r[2], r[5:3], r[11:6]),
				1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		end
		for (int i = 0; i < N_JUMP; i++) begin
			draw_random(r);
			draw_random(f);
			drive(instr_word(2'b11, r[0] ? 4'd12 : 4'd8, r[4], r[3:1], r[10:5]),
				1'b1, 1'b1, r[11], 1'b0, 1'b0, 1'b0, f[8:0]);
		end
		for (int i = 0; i < N_FORCE; i++) begin
			draw_random(r);
			draw_random(f);
			case (i % 4)
				0: drive(r, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, f[8:0]);  // p
				1: drive(instr_word(2'b11, 4'd11, r[0], r[3:1], r[9:4]),
					1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, f[8:0]);
				2: drive(instr_word(2'b01, r[0] ? 4'd14 : 4'd13, r[1], r[4:2], r[10:5]),
					1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, f[8:0]);
				default: drive(instr_word(2'b11, 4'd15, r[0], 3'd5, r[9:4]),
					1'b1, 1'b1, 1'b0, 1'b0, 1'b0, r[10], f[8:0]);  // md with mc_3
			endcase
		end
		for (int i = 0; i < N_ILLEGAL; i++) begin
			draw_random(r);
			a_bad = (r[3:2] == 2'b11) ? 3'd7 : 3'd5 + {1'b0, r[3:2]};
			b_bad = r[3] ? {1'b1, r[6:5]} : 3'd3;
			case (r[1:0])
				2'd0: drive(instr_word(r[4] ? {r[5], ~r[5]} : 2'b00, r[9:6], r[10], r[13:11],
					r[15:10]), 1'b1, 1'b1, r[4], 1'b0, 1'b0, 1'b0, '0);
				2'd1: drive(instr_word(2'b11, 4'd14, r[4], r[7:5], r[13:8]),
					1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0);
				2'd2: drive(instr_word(2'b11, 4'd11, r[4], a_bad, r[13:8]),
					1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0);
				default: drive(instr_word(2'b11, 4'd10, r[4], r[9:7], {b_bad, r[12:10]}),
					1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0);
			endcase
		end
		drive(16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);  // Drain last load
		drive(16'h0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
		@(negedge clk);
		$display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycles);
		if (error_count == 0 && check_count > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== tests/pd_checker.sv ====
/* Compares pd_unit against a model at every rising edge after reset.
   Its own copy of ir follows the strobe rule, so held words are checked too. */

`include "pd_defs.svh"

module pd_checker
	import pd_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`PD_IR_W-1:0] w,
	input  logic                strob1,
	input  logic                w_ir,
	input  logic                si1,
	input  logic                q,
	input  logic                p,
	input  logic                mc_3,
	input  cond_flags_s         r0,
	input  ir_word_u            ir,
	input  pd_ctrl_s            ctrl,
	output int                  check_count,
	output int                  error_count
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [`PD_IR_W-1:0] model_ir;
	pd_ctrl_s            expected_ctrl;

	// Expected decode of one word under the current inputs
	function automatic pd_ctrl_s ref_decode(input logic [15:0] word, input logic sup,
		input logic qi, input logic pi, input logic mci, input cond_flags_s flags);
		pd_ctrl_s   e;
		logic [1:0] grp;
		logic [3:0] op;
		logic [2:0] a;
		logic [2:0] b;
		logic       active;
		logic       taken;
		logic       priv;
		e = '0;
		grp = word[15:14];
		op = word[13:10];
		a = word[8:6];
		b = word[5:3];
		taken = 1'b1;
		// si1 blanks groups 01 and 10, group 11 always decodes
		active = (grp != 2'b00) && !(sup && grp != 2'b11) && !(grp == 2'b11 && op == 4'd14);
		if (active) begin
			case (grp)
				2'b01:   e.ops.g1[op] = 1'b1;
				2'b10:   e.ops.g2[op] = 1'b1;
				default: e.ops.g3[op] = 1'b1;
			endcase
		end
		e.illegal = !active;
		if (e.ops.g3[11]) begin  // S group
			if (a < 3'd5) e.sub.s_op[a] = 1'b1;
			else e.illegal = 1'b1;
		end
		if (e.ops.g3[15]) e.sub.bn_op[a] = 1'b1;
		if (e.ops.g3[10]) begin  // C group
			e.sub.c_shift = b;
			if (b >= 3'd3) e.illegal = 1'b1;
		end
		e.c0 = (word[2:0] == 3'd0);
		e.ka1 = |e.ops.g1[11:8];
		e.ka2 = e.ops.g3[9];
		if (e.ka1) begin
			e.imm = word[9] ? 16'd0 - {10'd0, word[5:0]} : {10'd0, word[5:0]};
		end
		e.md = e.ops.g3[15] && (a == 3'd5);
		priv = e.ops.g3[11] | e.ops.g1[13] | e.ops.g1[14];
		if (e.ops.g3[12]) begin  // J
			case (a)
				3'd1:    taken = flags.l;
				3'd2:    taken = flags.e;
				3'd3:    taken = flags.g;
				3'd4:    taken = flags.z;
				3'd5:    taken = flags.m;
				3'd6:    taken = !flags.e;
				default: taken = 1'b1;
			endcase
		end
		if (e.ops.g3[8]) begin  // JS
			case (a)
				3'd1:    taken = flags.v;
				3'd2:    taken = flags.m;
				3'd3:    taken = flags.c;
				3'd4:    taken = flags.y;
				3'd5:    taken = flags.x;
				3'd6:    taken = flags.l;
				3'd7:    taken = flags.g;
				default: taken = 1'b1;
			endcase
		end
		e.nef = e.illegal | pi | (qi & priv) | (e.md & mci) | !taken;
		return e;
	endfunction

	task automatic compare_field(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("Mismatch at %0t: ir %h, %s expected %h, got %h",
				$time, model_ir, name, expected, actual);
		end
	endtask

	initial begin
		check_count = 0;
		error_count = 0;
	end

	// Sample before this edge's load, then follow the load rule
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			model_ir = '0;
		end else begin
			expected_ctrl = ref_decode(model_ir, si1, q, p, mc_3, r0);
			check_count = check_count + 1;
			compare_field("ir", model_ir, ir);
			compare_field("ops", expected_ctrl.ops, ctrl.ops);
			compare_field("sub", expected_ctrl.sub, ctrl.sub);
			compare_field("ka1", expected_ctrl.ka1, ctrl.ka1);
			compare_field("ka2", expected_ctrl.ka2, ctrl.ka2);
			compare_field("illegal", expected_ctrl.illegal, ctrl.illegal);
			compare_field("nef", expected_ctrl.nef, ctrl.nef);
			compare_field("md", expected_ctrl.md, ctrl.md);
			compare_field("imm", expected_ctrl.imm, ctrl.imm);
			compare_field("c0", expected_ctrl.c0, ctrl.c0);
			if (strob1 && w_ir) begin
				model_ir = w;
			end
		end
	end

endmodule

// ==== logic/pd_unit.sv ====
/* P-D decoder top. ir and ctrl settle one clock after the load edge;
   r0, q, p and mc_3 act on ctrl in the same cycle. */

`include "pd_defs.svh"

module pd_unit
	import pd_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`PD_IR_W-1:0] w,
	input  logic                strob1,
	input  logic                w_ir,
	input  logic                si1,     // Group decode suppression
	input  logic                q,
	input  logic                p,
	input  logic                mc_3,
	input  cond_flags_s         r0,
	output ir_word_u            ir,
	output pd_ctrl_s            ctrl
);

	logic [`PD_GROUPS-1:0][`PD_OPS_PER_GROUP-1:0] group_ops;
	logic [`PD_GROUPS-1:0]                        legal;

	op_groups_s          ops;
	sub_ops_s            sub;
	logic                ka1;
	logic                ka2;
	logic [`PD_IR_W-1:0] imm;
	logic                c0;
	logic                illegal;
	logic                nef;
	logic                md;

	instr_reg u_instr_reg (
		.clk    (clk),
		.rst_n  (rst_n),
		.w      (w),
		.strob1 (strob1),
		.w_ir   (w_ir),
		.ir     (ir)
	);

	// Slice 0 is group 01
	for (genvar gi = 0; gi < `PD_GROUPS; gi++) begin : g_grp
		group_decoder #(
			.GROUP (gi + 1)
		) u_group_decoder (
			.ir    (ir),
			.si1   (si1),
			.ops   (group_ops[gi]),
			.legal (legal[gi])
		);
	end

	assign ops.g1 = group_ops[0];
	assign ops.g2 = group_ops[1];
	assign ops.g3 = group_ops[2];

	sub_op_decoder u_sub_op_decoder (
		.ir   (ir),
		.ops  (ops),
		.sub  (sub),
		.ka1  (ka1),
		.ka2  (ka2),
		.imm  (imm),
		.c0   (c0)
	);

	cond_eval u_cond_eval (
		.ir      (ir),
		.ops     (ops),
		.sub     (sub),
		.legal   (legal),
		.q       (q),
		.p       (p),
		.mc_3    (mc_3),
		.r0      (r0),
		.illegal (illegal),
		.nef     (nef),
		.md      (md)
	);

	always_comb begin
		ctrl.ops     = ops;
		ctrl.sub     = sub;
		ctrl.ka1     = ka1;
		ctrl.ka2     = ka2;
		ctrl.illegal = illegal;
		ctrl.nef     = nef;
		ctrl.md      = md;
		ctrl.imm     = imm;
		ctrl.c0      = c0;
	end

endmodule

// ==== logic/cond_eval.sv ====
/* Illegal and ineffective instruction flags, purely combinational.
   Suppressed groups have no active lines and so read as illegal. */

`include "pd_defs.svh"

module cond_eval
	import pd_pkg::*;
(
	input  ir_word_u                 ir,
	input  op_groups_s               ops,
	input  sub_ops_s                 sub,
	input  logic [`PD_GROUPS-1:0]    legal,
	input  logic                     q,      // User mode
	input  logic                     p,      // Skip pending
	input  logic                     mc_3,
	input  cond_flags_s              r0,
	output logic                     illegal,
	output logic                     nef,
	output logic                     md
);

	localparam int G1_OU = 13;
	localparam int G1_IN = 14;
	localparam int G3_JS = 8;
	localparam int G3_C  = 10;
	localparam int G3_S  = 11;
	localparam int G3_J  = 12;

	logic grp0;
	logic s_bad;
	logic c_bad;
	logic priv;
	logic j_flag;
	logic js_flag;
	logic jump_fail;

	assign grp0 = (ir.fields.grp == '0);

	// S codes 5..7 and C codes B=3..7 are unused
	assign s_bad = ops.g3[G3_S] & (ir.fields.a >= `PD_S_OPS);
	assign c_bad = ops.g3[G3_C] & (ir.fields.b[2] | (&ir.fields.b[1:0]));

	assign illegal = grp0 | ~|legal | s_bad | c_bad;

	// S group and I/O are privileged
	assign priv = ops.g3[G3_S] | ops.g1[G1_OU] | ops.g1[G1_IN];

	assign md = sub.bn_op[5];

	// J condition
	always_comb begin
		case (ir.fields.a)
			3'd1:    j_flag = r0.l;
			3'd2:    j_flag = r0.e;
			3'd3:    j_flag = r0.g;
			3'd4:    j_flag = r0.z;
			3'd5:    j_flag = r0.m;
			3'd6:    j_flag = ~r0.e;  // JN
			default: j_flag = 1'b1;   // Unconditional
		endcase
	end

	// JS condition
	always_comb begin
		case (ir.fields.a)
			3'd1:    js_flag = r0.v;
			3'd2:    js_flag = r0.m;
			3'd3:    js_flag = r0.c;
			3'd4:    js_flag = r0.y;
			3'd5:    js_flag = r0.x;
			3'd6:    js_flag = r0.l;
			3'd7:    js_flag = r0.g;
			default: js_flag = 1'b1;
		endcase
	end

	assign jump_fail = (ops.g3[G3_J] & ~j_flag) | (ops.g3[G3_JS] & ~js_flag);

	assign nef = illegal | p | (q & priv) | (md & mc_3) | jump_fail;

endmodule

// ==== logic/sub_op_decoder.sv ====
/* S, BN and C sub-operations and the short-argument class.
   imm is nonzero only for ka1 instructions; other words give zero. */

`include "pd_defs.svh"

module sub_op_decoder
	import pd_pkg::*;
(
	input  ir_word_u            ir,
	input  op_groups_s          ops,
	output sub_ops_s            sub,
	output logic                ka1,
	output logic                ka2,
	output logic [`PD_IR_W-1:0] imm,
	output logic                c0
);

	localparam int G3_C  = 10;
	localparam int G3_S  = 11;
	localparam int G3_BN = 15;
	localparam int G3_KA2 = 9;

	logic                is_s;
	logic                is_bn;
	logic                is_c;
	logic [`PD_IR_W-1:0] t_ext;
	logic [`PD_IR_W-1:0] t_neg;

	assign is_s  = ops.g3[G3_S];
	assign is_bn = ops.g3[G3_BN];
	assign is_c  = ops.g3[G3_C];

	// S group, A selects one of five
	always_comb begin
		sub.s_op = '0;
		if (is_s && (ir.fields.a < `PD_S_OPS)) begin
			sub.s_op[ir.fields.a] = 1'b1;
		end
	end

	// BN group uses all eight A codes
	always_comb begin
		sub.bn_op = '0;
		if (is_bn) begin
			sub.bn_op[ir.fields.a] = 1'b1;
		end
	end

	assign sub.c_shift = is_c ? ir.fields.b : '0;  // Shift selector

	assign c0 = ~|ir.fields.c;

	// Short-argument classes
	assign ka1 = |ops.g1[11:8];  // Codes 8 to 11
	assign ka2 = ops.g3[G3_KA2];

	// T is a magnitude, D gives the sign
	assign t_ext = {{(`PD_IR_W-`PD_SHORT_W){1'b0}}, ir.short_form.t};
	assign t_neg = ~t_ext + 1'b1;

	always_comb begin
		if (!ka1) begin
			imm = '0;
		end else if (ir.short_form.d) begin
			imm = t_neg;
		end else begin
			imm = t_ext;
		end
	end

endmodule

// ==== logic/group_decoder.sv ====
/* One major group. GROUP is the grp code, 1 to 3.
   Only assigned opcodes raise a line; reserved codes leave ops at zero. */

`include "pd_defs.svh"

module group_decoder
	import pd_pkg::*;
#(
	parameter int GROUP = 1
) (
	input  ir_word_u                     ir,
	input  logic                         si1,
	output logic [`PD_OPS_PER_GROUP-1:0] ops,
	output logic                         legal
);

	localparam logic [`PD_OPS_PER_GROUP-1:0] VALID =
		(GROUP == 1) ? `PD_G1_VALID :
		(GROUP == 2) ? `PD_G2_VALID : `PD_G3_VALID;

	logic sup;
	logic en;

	// si1 only affects groups 01 and 10
	assign sup = (GROUP == 1) ? (si1 & ir.fields.grp[0]) :
	             (GROUP == 2) ? (si1 & ir.fields.grp[1]) : 1'b0;

	assign en = (ir.fields.grp == GROUP[`PD_GRP_W-1:0]) & ~sup;

	always_comb begin
		ops = '0;
		if (en) begin
			ops[ir.fields.op] = VALID[ir.fields.op];  // Mask reserved codes
		end
	end

	assign legal = |ops;

endmodule

// ==== logic/instr_reg.sv ====
/* Loads on a clock edge while strob1 and w_ir are both high.
   Clears to zero on reset, which decodes as illegal group 00. */

`include "pd_defs.svh"

module instr_reg
	import pd_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`PD_IR_W-1:0] w,       // Bus word
	input  logic                strob1,
	input  logic                w_ir,
	output ir_word_u            ir
);

	logic load;

	assign load = strob1 & w_ir;  // Both strobes required

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir <= '0;
		end else if (load) begin
			ir <= w;
		end
	end

endmodule

// ==== logic/pd_pkg.sv ====
/* Types for the P-D decoder. Struct fields are declared MSB first,
   so grp sits in bits 15:14 of the instruction word. */

`include "pd_defs.svh"

package pd_pkg;

	// Register-argument layout
	typedef struct packed {
		logic [`PD_GRP_W-1:0]   grp;
		logic [`PD_OP_W-1:0]    op;
		logic                   d;
		logic [`PD_FIELD_W-1:0] a;
		logic [`PD_FIELD_W-1:0] b;
		logic [`PD_FIELD_W-1:0] c;
	} ir_fields_s;

	// Short-argument layout, B and C merged into T
	typedef struct packed {
		logic [`PD_GRP_W-1:0]   grp;
		logic [`PD_OP_W-1:0]    op;
		logic                   d;
		logic [`PD_FIELD_W-1:0] a;
		logic [`PD_SHORT_W-1:0] t;
	} ir_short_s;

	typedef union packed {
		ir_fields_s fields;
		ir_short_s  short_form;
	} ir_word_u;

	// One-hot opcode lines, one vector per major group
	typedef struct packed {
		logic [`PD_OPS_PER_GROUP-1:0] g1;  // Group 01
		logic [`PD_OPS_PER_GROUP-1:0] g2;  // Group 10
		logic [`PD_OPS_PER_GROUP-1:0] g3;  // Group 11
	} op_groups_s;

	// r0 flags in register order
	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
		logic l;
		logic e;
		logic g;
		logic y;
		logic x;
	} cond_flags_s;

	typedef struct packed {
		logic [`PD_S_OPS-1:0]   s_op;     // Indexed by A
		logic [`PD_BN_OPS-1:0]  bn_op;    // Indexed by A
		logic [`PD_FIELD_W-1:0] c_shift;  // B field of C group
	} sub_ops_s;

	typedef struct packed {
		op_groups_s          ops;
		sub_ops_s            sub;
		logic                ka1;
		logic                ka2;
		logic                illegal;
		logic                nef;
		logic                md;
		logic [`PD_IR_W-1:0] imm;
		logic                c0;
	} pd_ctrl_s;

endpackage

// ==== logic/pd_defs.svh ====
/* Field layout of the 16-bit instruction word, group MSB first.
   Valid masks mark assigned opcodes per group; bit n is opcode n. */

`ifndef PD_DEFS_SVH
`define PD_DEFS_SVH

`define PD_IR_W           16  // Instruction word
`define PD_GRP_W          2   // Major group selector
`define PD_OP_W           4   // Opcode within a group
`define PD_FIELD_W        3   // A, B and C register fields
`define PD_SHORT_W        6   // Short argument T
`define PD_GROUPS         3   // Groups 01, 10 and 11
`define PD_OPS_PER_GROUP  16
`define PD_FLAGS_W        9   // r0 condition flags

`define PD_S_OPS          5   // HLT MCL SIN GI LIP
`define PD_BN_OPS         8   // MB IM KI FI SP MD RZ IB

// Assigned opcodes
`define PD_G1_VALID       16'hffff
`define PD_G2_VALID       16'hffff
`define PD_G3_VALID       16'hbfff  // Code 14 reserved

`endif
